//--- Makefile
# Verilator build and run of the control unit testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f verilog.f --top-module controlUnitTb -o simControlUnit

# The run fails unless the pass message shows up in the output
run: compile
	./obj_dir/simControlUnit | awk '{ print } /^Simulation passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

//--- design/controlPkg.sv
`default_nettype none

package controlPkg;

	localparam int opWidth = 6;
	localparam int aluOpWidth = 3;
	localparam int aluSrcAWidth = 2;
	localparam int aluSrcBWidth = 3;
	localparam int pcSourceWidth = 3;
	localparam int iOrDWidth = 3;
	localparam int memToRegWidth = 4;
	localparam int regDstWidth = 2;
	localparam int loadSizeWidth = 2;

	// Major opcode field
	typedef enum logic [opWidth-1:0] {
		opRType = 6'h00,
		opJump = 6'h02,
		opJal = 6'h03,
		opBeq = 6'h04,
		opBne = 6'h05,
		opBle = 6'h06,
		opBgt = 6'h07,
		opAddi = 6'h08,
		opAddiu = 6'h09,
		opLui = 6'h0f,
		opLb = 6'h20,
		opLh = 6'h21,
		opLw = 6'h23
	} opcode_e;

	// Funct field, only meaningful with opRType
	typedef enum logic [opWidth-1:0] {
		functJr = 6'h08,
		functAdd = 6'h20,
		functSub = 6'h22,
		functAnd = 6'h24,
		functSlt = 6'h2a
	} funct_e;

	typedef enum logic [4:0] {
		kindAdd, kindAnd, kindSub, kindSlt, kindJr,
		kindAddi, kindAddiu,
		kindBeq, kindBne, kindBgt, kindBle,
		kindLw, kindLh, kindLb,
		kindLui, kindJ, kindJal,
		kindUnknown
	} instrKind_e;

	// Encodings understood by the datapath ALU
	typedef enum logic [aluOpWidth-1:0] {
		aluLoad = 3'd0,
		aluAdd = 3'd1,
		aluSub = 3'd2,
		aluAnd = 3'd3,
		aluCompare = 3'd7
	} aluOp_e;

	typedef enum logic [5:0] {
		stResetInit, stStart, stFetchWait, stDecode,
		stAluRegister, stWriteRegister, stSltWrite, stJumpRegister,
		stImmAdd, stImmAddUnsigned, stWriteImmediate, stOverflowTrap,
		stBranchTarget, stBranchCompare,
		stLoadAddress, stLoadWait, stLoadWord, stLoadHalf, stLoadByte,
		stLuiCompute, stLuiWrite, stJump, stJalLink, stJalWrite,
		stWait
	} state_e;

	typedef enum logic [loadSizeWidth-1:0] {
		sizeWord = 2'd0,
		sizeHalf = 2'd1,
		sizeByte = 2'd2
	} loadSize_e;

endpackage

`default_nettype wire

//--- design/controlUnit.sv
`timescale 1ns/10ps
`default_nettype none

module controlUnit import controlPkg::*; #(
	parameter int memWaitCycles = 2
) (
	input logic clock,
	input logic reset,
	input logic [opWidth-1:0] opCode,
	input logic [opWidth-1:0] funct,
	input logic overflow,
	input logic equal,
	input logic greater,
	output logic [aluSrcAWidth-1:0] aluSrcA,
	output logic [aluSrcBWidth-1:0] aluSrcB,
	output logic [pcSourceWidth-1:0] pcSource,
	output logic [aluOpWidth-1:0] aluOp,
	output logic pcWrite,
	output logic irWrite,
	output logic [iOrDWidth-1:0] iOrD,
	output logic [memToRegWidth-1:0] memToReg,
	output logic writeRegA,
	output logic writeRegB,
	output logic aluOutControl,
	output logic [regDstWidth-1:0] regDst,
	output logic regWrite,
	output logic epcWrite,
	output logic [loadSizeWidth-1:0] loadSize,
	output logic memDataReg
);

	opcode_e opCodeField;
	funct_e functField;
	instrKind_e instrKind;
	state_e state;
	logic lastWait;
	aluOp_e aluOpValue;
	loadSize_e loadSizeValue;

	// Raw instruction fields may hold codes outside the enums
	assign opCodeField = opcode_e'(opCode);
	assign functField = funct_e'(funct);
	assign aluOp = aluOpValue;
	assign loadSize = loadSizeValue;

	instructionDecoder decoder (
		.opCode(opCodeField),
		.funct(functField),
		.instrKind(instrKind)
	);

	stateSequencer #(
		.memWaitCycles(memWaitCycles)
	) sequencer (
		.clock(clock),
		.reset(reset),
		.instrKind(instrKind),
		.overflow(overflow),
		.state(state),
		.lastWait(lastWait)
	);

	controlWordTable wordTable (
		.state(state),
		.lastWait(lastWait),
		.equal(equal),
		.greater(greater),
		.branchSense(instrKind),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.pcSource(pcSource),
		.iOrD(iOrD),
		.memToReg(memToReg),
		.regDst(regDst),
		.aluOp(aluOpValue),
		.loadSize(loadSizeValue),
		.pcWrite(pcWrite),
		.irWrite(irWrite),
		.writeRegA(writeRegA),
		.writeRegB(writeRegB),
		.aluOutControl(aluOutControl),
		.regWrite(regWrite),
		.epcWrite(epcWrite),
		.memDataReg(memDataReg)
	);

endmodule

`default_nettype wire

//--- design/controlWordTable.sv
`timescale 1ns/10ps
`default_nettype none

module controlWordTable import controlPkg::*; (
	input state_e state,
	input logic lastWait,
	input logic equal,
	input logic greater,
	input instrKind_e branchSense,
	output logic [aluSrcAWidth-1:0] aluSrcA,
	output logic [aluSrcBWidth-1:0] aluSrcB,
	output logic [pcSourceWidth-1:0] pcSource,
	output logic [iOrDWidth-1:0] iOrD,
	output logic [memToRegWidth-1:0] memToReg,
	output logic [regDstWidth-1:0] regDst,
	output aluOp_e aluOp,
	output loadSize_e loadSize,
	output logic pcWrite,
	output logic irWrite,
	output logic writeRegA,
	output logic writeRegB,
	output logic aluOutControl,
	output logic regWrite,
	output logic epcWrite,
	output logic memDataReg
);

	logic branchTaken;

	always_comb begin
		case (branchSense)
			kindBeq: branchTaken = equal;
			kindBne: branchTaken = !equal;
			kindBgt: branchTaken = greater;
			kindBle: branchTaken = !greater;
			default: branchTaken = 1'b0;
		endcase
	end

	always_comb begin
		aluSrcA = 2'd0;
		aluSrcB = 3'd0;
		pcSource = 3'd0;
		iOrD = 3'd0;
		memToReg = 4'd0;
		regDst = 2'd0;
		aluOp = aluLoad;
		loadSize = sizeWord;
		pcWrite = 1'b0;
		irWrite = 1'b0;
		writeRegA = 1'b0;
		writeRegB = 1'b0;
		aluOutControl = 1'b0;
		regWrite = 1'b0;
		epcWrite = 1'b0;
		memDataReg = 1'b0;
		case (state)
			stResetInit: begin
				regDst = 2'd1;
				regWrite = 1'b1;
				epcWrite = 1'b1;
			end
			// PC + 4
			stStart: begin
				aluSrcB = 3'd1;
				aluOp = aluAdd;
				pcWrite = 1'b1;
			end
			stFetchWait: irWrite = lastWait;
			stDecode: begin
				writeRegA = 1'b1;
				writeRegB = 1'b1;
			end
			stAluRegister: begin
				aluSrcA = 2'd2;
				aluOutControl = 1'b1;
				case (branchSense)
					kindAnd: aluOp = aluAnd;
					kindSub: aluOp = aluSub;
					default: aluOp = aluAdd;
				endcase
			end
			stWriteRegister: begin
				regDst = 2'd3;
				regWrite = 1'b1;
			end
			stSltWrite: begin
				aluSrcA = 2'd2;
				aluOp = aluCompare;
				memToReg = 4'd8;
				writeRegA = 1'b1;
				writeRegB = 1'b1;
				regDst = 2'd3;
				regWrite = 1'b1;
			end
			stJumpRegister: begin
				pcSource = 3'd4;
				pcWrite = 1'b1;
				writeRegA = 1'b1;
			end
			stImmAdd, stImmAddUnsigned: begin
				aluSrcA = 2'd2;
				aluSrcB = 3'd2;
				aluOp = aluAdd;
				aluOutControl = 1'b1;
			end
			stWriteImmediate: regWrite = 1'b1;
			stOverflowTrap: begin
				iOrD = 3'd3;
				epcWrite = 1'b1;
			end
			// Target address goes to ALUOut while the registers are compared
			stBranchTarget: begin
				aluSrcB = 3'd3;
				aluOp = aluAdd;
				aluOutControl = 1'b1;
			end
			stBranchCompare: begin
				aluSrcA = 2'd2;
				pcSource = 3'd1;
				aluOp = aluCompare;
				writeRegA = 1'b1;
				writeRegB = 1'b1;
				pcWrite = branchTaken;
			end
			stLoadAddress: begin
				aluSrcA = 2'd2;
				aluSrcB = 3'd2;
				aluOp = aluAdd;
				writeRegA = 1'b1;
				aluOutControl = 1'b1;
			end
			// Address held from ALUOut for the whole memory wait
			stLoadWait: begin
				iOrD = 3'd1;
				memDataReg = lastWait;
			end
			stLoadWord, stLoadHalf, stLoadByte: begin
				memToReg = 4'd3;
				regWrite = 1'b1;
				if (state == stLoadHalf) begin
					loadSize = sizeHalf;
				end else if (state == stLoadByte) begin
					loadSize = sizeByte;
				end
			end
			stLuiCompute: begin
				aluSrcA = 2'd1;
				aluSrcB = 3'd2;
				aluOp = aluAdd;
				aluOutControl = 1'b1;
			end
			stLuiWrite: regWrite = 1'b1;
			stJump: begin
				pcSource = 3'd2;
				pcWrite = 1'b1;
			end
			stJalLink: aluOutControl = 1'b1;
			stJalWrite: begin
				regDst = 2'd2;
				regWrite = 1'b1;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

//--- design/instructionDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module instructionDecoder import controlPkg::*; (
	input opcode_e opCode,
	input funct_e funct,
	output instrKind_e instrKind
);

	always_comb begin
		instrKind = kindUnknown;
		case (opCode)
			opRType: begin
				case (funct)
					functAdd: instrKind = kindAdd;
					functAnd: instrKind = kindAnd;
					functSub: instrKind = kindSub;
					functSlt: instrKind = kindSlt;
					functJr: instrKind = kindJr;
					default: instrKind = kindUnknown;
				endcase
			end
			opAddi: instrKind = kindAddi;
			opAddiu: instrKind = kindAddiu;
			opBeq: instrKind = kindBeq;
			opBne: instrKind = kindBne;
			opBgt: instrKind = kindBgt;
			opBle: instrKind = kindBle;
			opLw: instrKind = kindLw;
			opLh: instrKind = kindLh;
			opLb: instrKind = kindLb;
			opLui: instrKind = kindLui;
			opJump: instrKind = kindJ;
			opJal: instrKind = kindJal;
			default: instrKind = kindUnknown;
		endcase
	end

endmodule

`default_nettype wire

//--- design/stateSequencer.sv
`timescale 1ns/10ps
`default_nettype none

module stateSequencer import controlPkg::*; #(
	parameter int memWaitCycles = 2
) (
	input logic clock,
	input logic reset,
	input instrKind_e instrKind,
	input logic overflow,
	output state_e state,
	output logic lastWait
);

	localparam int countWidth = (memWaitCycles > 1) ? $clog2(memWaitCycles) : 1;

	state_e nextState;
	logic [countWidth-1:0] waitCount;
	logic inWait;

	// Fetch and load share one wait counter
	assign inWait = (state == stFetchWait) || (state == stLoadWait);
	assign lastWait = inWait && (waitCount == countWidth'(memWaitCycles - 1));

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= stResetInit;
		end else begin
			state <= nextState;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			waitCount <= '0;
		end else if (inWait && !lastWait) begin
			waitCount <= waitCount + 1'b1;
		end else begin
			waitCount <= '0;
		end
	end

	always_comb begin
		nextState = stWait;
		case (state)
			stResetInit: nextState = stStart;
			stStart: nextState = stFetchWait;
			stFetchWait: nextState = lastWait ? stDecode : stFetchWait;
			stDecode: begin
				case (instrKind)
					kindAdd, kindAnd, kindSub: nextState = stAluRegister;
					kindSlt: nextState = stSltWrite;
					kindJr: nextState = stJumpRegister;
					kindAddi: nextState = stImmAdd;
					kindAddiu: nextState = stImmAddUnsigned;
					kindBeq, kindBne, kindBgt, kindBle: nextState = stBranchTarget;
					kindLw, kindLh, kindLb: nextState = stLoadAddress;
					kindLui: nextState = stLuiCompute;
					kindJ: nextState = stJump;
					kindJal: nextState = stJalLink;
					// Unknown codes retire without side effects
					default: nextState = stWait;
				endcase
			end
			stAluRegister: nextState = stWriteRegister;
			stWriteRegister: nextState = stWait;
			stSltWrite: nextState = stWait;
			stJumpRegister: nextState = stWait;
			stImmAdd: nextState = overflow ? stOverflowTrap : stWriteImmediate;
			stImmAddUnsigned: nextState = stWriteImmediate;
			stWriteImmediate: nextState = stWait;
			stOverflowTrap: nextState = stWait;
			stBranchTarget: nextState = stBranchCompare;
			stBranchCompare: nextState = stWait;
			stLoadAddress: nextState = stLoadWait;
			stLoadWait: begin
				if (!lastWait) begin
					nextState = stLoadWait;
				end else begin
					case (instrKind)
						kindLh: nextState = stLoadHalf;
						kindLb: nextState = stLoadByte;
						default: nextState = stLoadWord;
					endcase
				end
			end
			stLoadWord: nextState = stWait;
			stLoadHalf: nextState = stWait;
			stLoadByte: nextState = stWait;
			stLuiCompute: nextState = stLuiWrite;
			stLuiWrite: nextState = stWait;
			stJump: nextState = stWait;
			// Link first, then reuse the plain jump state
			stJalLink: nextState = stJalWrite;
			stJalWrite: nextState = stJump;
			stWait: nextState = stStart;
			default: nextState = stWait;
		endcase
	end

endmodule

`default_nettype wire

//--- tests/clockGen.sv
`timescale 1ns/10ps
`default_nettype none

module clockGen (
	output logic clock
);

	// 4 ns period
	initial begin
		clock = 1'b0;
		forever begin
			#2 clock = ~clock;
		end
	end

endmodule

`default_nettype wire

//--- tests/controlUnitTb.sv
`timescale 1ns/10ps
`default_nettype none

module controlUnitTb import controlPkg::*; ();

	localparam int memWaitCycles = 2;
	localparam int perTest = 40;
	localparam int timeoutNs = 5 * perTest * 12 * 4;

	// Instruction kinds, grouped so each test draws from a contiguous range
	localparam int kAdd = 0, kAnd = 1, kSub = 2, kSlt = 3, kJr = 4;
	localparam int kAddi = 5, kAddiu = 6;
	localparam int kBeq = 7, kBne = 8, kBgt = 9, kBle = 10;
	localparam int kLw = 11, kLh = 12, kLb = 13, kLui = 14;
	localparam int kJ = 15, kJal = 16, kUnknown = 17;

	localparam int sReset = 0, sStart = 1, sFetch = 2, sDecode = 3, sAluReg = 4;
	localparam int sWriteReg = 5, sSlt = 6, sJr = 7, sImm = 8, sImmU = 9;
	localparam int sWriteImm = 10, sTrap = 11, sBrTarget = 12, sBrCompare = 13;
	localparam int sLdAddr = 14, sLdWait = 15, sLdWrite = 16, sLui1 = 17, sLui2 = 18;
	localparam int sJump = 19, sJalLink = 20, sJalWrite = 21, sWait = 22;

	logic clock;
	logic reset;
	logic [opWidth-1:0] opCode;
	logic [opWidth-1:0] funct;
	logic overflow;
	logic equal;
	logic greater;
	logic [aluSrcAWidth-1:0] aluSrcA;
	logic [aluSrcBWidth-1:0] aluSrcB;
	logic [pcSourceWidth-1:0] pcSource;
	logic [aluOpWidth-1:0] aluOp;
	logic pcWrite;
	logic irWrite;
	logic [iOrDWidth-1:0] iOrD;
	logic [memToRegWidth-1:0] memToReg;
	logic writeRegA;
	logic writeRegB;
	logic aluOutControl;
	logic [regDstWidth-1:0] regDst;
	logic regWrite;
	logic epcWrite;
	logic [loadSizeWidth-1:0] loadSize;
	logic memDataReg;

	int modelState;
	int waitIdx;
	int currentKind;
	int pendingKind;
	int lastChecked;
	bit loadNext;
	int errorCount;
	int checkCount;
	logic [31:0] rngState;

	// One nibble per output, most significant first
	string fieldNames [16] = '{
		"aluSrcA", "aluSrcB", "pcSource", "aluOp",
		"pcWrite", "irWrite", "iOrD", "memToReg",
		"writeRegA", "writeRegB", "aluOutControl", "regDst",
		"regWrite", "epcWrite", "loadSize", "memDataReg"
	};

	clockGen clocks (
		.clock(clock)
	);

	controlUnit #(
		.memWaitCycles(memWaitCycles)
	) uut (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] drawRandom();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	task automatic compareValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("Mismatch at %0d ns: %s is %0h, expected %0h", $time, name, actual, expected);
		end
	endtask

	function automatic logic [63:0] expectedWord(input int st, input int kind, input logic last,
			input logic eq, input logic gt);
		logic taken;
		logic [63:0] aluCode;
		logic [63:0] sizeCode;
		logic [63:0] w;
		taken = (kind == kBeq && eq) || (kind == kBne && !eq) ||
			(kind == kBgt && gt) || (kind == kBle && !gt);
		aluCode = (kind == kAnd) ? 64'd3 : (kind == kSub) ? 64'd2 : 64'd1;
		sizeCode = (kind == kLh) ? 64'd1 : (kind == kLb) ? 64'd2 : 64'd0;
		case (st)
			sReset: w = 64'h0000_0000_0001_1100;
			sStart: w = 64'h0101_1000_0000_0000;
			sFetch: w = last ? 64'h0000_0100_0000_0000 : 64'h0;
			sDecode: w = 64'h0000_0000_1100_0000;
			sAluReg: w = 64'h2000_0000_0010_0000 | (aluCode << 48);
			sWriteReg: w = 64'h0000_0000_0003_1000;
			sSlt: w = 64'h2007_0008_1103_1000;
			sJr: w = 64'h0040_1000_1000_0000;
			sImm, sImmU: w = 64'h2201_0000_0010_0000;
			sWriteImm: w = 64'h0000_0000_0000_1000;
			sTrap: w = 64'h0000_0030_0000_0100;
			sBrTarget: w = 64'h0301_0000_0010_0000;
			sBrCompare: w = taken ? 64'h2017_1000_1100_0000 : 64'h2017_0000_1100_0000;
			sLdAddr: w = 64'h2201_0000_1010_0000;
			sLdWait: w = last ? 64'h0000_0010_0000_0001 : 64'h0000_0010_0000_0000;
			sLdWrite: w = 64'h0000_0003_0000_1000 | (sizeCode << 4);
			sLui1: w = 64'h1201_0000_0010_0000;
			sLui2: w = 64'h0000_0000_0000_1000;
			sJump: w = 64'h0020_1000_0000_0000;
			sJalLink: w = 64'h0000_0000_0010_0000;
			sJalWrite: w = 64'h0000_0000_0002_1000;
			default: w = 64'h0;
		endcase
		return w;
	endfunction

	function automatic int decodeTarget(input int kind);
		case (kind)
			kAdd, kAnd, kSub: return sAluReg;
			kSlt: return sSlt;
			kJr: return sJr;
			kAddi: return sImm;
			kAddiu: return sImmU;
			kBeq, kBne, kBgt, kBle: return sBrTarget;
			kLw, kLh, kLb: return sLdAddr;
			kLui: return sLui1;
			kJ: return sJump;
			kJal: return sJalLink;
			default: return sWait;
		endcase
	endfunction

	task automatic driveInstruction(input int kind);
		logic [31:0] r;
		r = drawRandom();
		opCode <= opRType;
		// Funct is noise for everything but R-type
		funct <= r[5:0];
		case (kind)
			kAdd: funct <= functAdd;
			kAnd: funct <= functAnd;
			kSub: funct <= functSub;
			kSlt: funct <= functSlt;
			kJr: funct <= functJr;
			kAddi: opCode <= opAddi;
			kAddiu: opCode <= opAddiu;
			kBeq: opCode <= opBeq;
			kBne: opCode <= opBne;
			kBgt: opCode <= opBgt;
			kBle: opCode <= opBle;
			kLw: opCode <= opLw;
			kLh: opCode <= opLh;
			kLb: opCode <= opLb;
			kLui: opCode <= opLui;
			kJ: opCode <= opJump;
			kJal: opCode <= opJal;
			default: begin
				if (r[7:6] == 2'd0) begin
					funct <= 6'h01;
				end else begin
					opCode <= r[6] ? 6'h10 : 6'h3f;
				end
			end
		endcase
	endtask

	task automatic checkAndAdvance();
		logic last;
		logic [63:0] expected;
		logic [63:0] actual;
		last = (waitIdx == memWaitCycles - 1);
		expected = expectedWord(modelState, currentKind, last, equal, greater);
		actual = {4'(aluSrcA), 4'(aluSrcB), 4'(pcSource), 4'(aluOp),
			4'(pcWrite), 4'(irWrite), 4'(iOrD), 4'(memToReg),
			4'(writeRegA), 4'(writeRegB), 4'(aluOutControl), 4'(regDst),
			4'(regWrite), 4'(epcWrite), 4'(loadSize), 4'(memDataReg)};
		for (int i = 0; i < 16; i++) begin
			compareValue(fieldNames[i], 32'(actual[63 - 4 * i -: 4]),
				32'(expected[63 - 4 * i -: 4]));
		end
		// Instruction register loads after the last fetch wait
		if (modelState == sFetch && last) begin
			loadNext = 1'b1;
		end
		lastChecked = modelState;
		case (modelState)
			sReset: modelState = sStart;
			sStart, sLdAddr: begin
				modelState = (modelState == sStart) ? sFetch : sLdWait;
				waitIdx = 0;
			end
			sFetch, sLdWait: begin
				if (!last) begin
					waitIdx = waitIdx + 1;
				end else begin
					modelState = (modelState == sFetch) ? sDecode : sLdWrite;
				end
			end
			sDecode: modelState = decodeTarget(currentKind);
			sAluReg: modelState = sWriteReg;
			sImm: modelState = overflow ? sTrap : sWriteImm;
			sImmU: modelState = sWriteImm;
			sBrTarget: modelState = sBrCompare;
			sLui1: modelState = sLui2;
			sJalLink: modelState = sJalWrite;
			sJalWrite: modelState = sJump;
			sWait: modelState = sStart;
			default: modelState = sWait;
		endcase
	endtask

	task automatic cycle();
		logic [31:0] r;
		@(posedge clock);
		r = drawRandom();
		overflow <= r[0];
		equal <= r[1];
		greater <= r[2];
		if (loadNext) begin
			driveInstruction(pendingKind);
			currentKind = pendingKind;
			loadNext = 1'b0;
		end
		@(negedge clock);
		checkAndAdvance();
	endtask

	task automatic runInstruction(input int kind);
		pendingKind = kind;
		lastChecked = -1;
		while (lastChecked != sWait) begin
			cycle();
		end
	endtask

	task automatic runTest(input string name, input int firstKind, input int kindCount);
		int errorsBefore;
		logic [31:0] r;
		errorsBefore = errorCount;
		for (int n = 0; n < perTest; n++) begin
			r = drawRandom();
			runInstruction(firstKind + int'(r % kindCount));
		end
		$display("Test %s: %0d instructions, %0d mismatches", name, perTest,
			errorCount - errorsBefore);
	endtask

	initial begin
		rngState = 32'h0794_5b18;
		errorCount = 0;
		checkCount = 0;
		modelState = sReset;
		waitIdx = 0;
		currentKind = kUnknown;
		pendingKind = kUnknown;
		lastChecked = -1;
		loadNext = 1'b0;
		reset = 1'b1;
		opCode = '0;
		funct = '0;
		overflow = 1'b0;
		equal = 1'b0;
		greater = 1'b0;
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		checkAndAdvance();
		$display("Test reset: %0d mismatches", errorCount);
		runTest("R-type", kAdd, 5);
		runTest("immediate", kAddi, 2);
		runTest("branch", kBeq, 4);
		runTest("load and lui", kLw, 4);
		runTest("jump and unknown", kJ, 3);
		$display("Tests: 6, checks: %0d, mismatches: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		#(timeoutNs);
		$display("Timeout: the instruction stream did not finish within %0d ns", timeoutNs);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
design/controlPkg.sv
design/instructionDecoder.sv
design/stateSequencer.sv
design/controlWordTable.sv
design/controlUnit.sv
tests/clockGen.sv
tests/controlUnitTb.sv
